// ==== design/aes_pkg.sv ====
//////////////////////////////
// AES package
// Shared types, S-box table, GF(2^8) doubling and round constants
//////////////////////////////
package aes_pkg;

  typedef logic [7:0]   byte_t;
  // Byte 0 sits in bits 127:120, state filled column by column
  typedef logic [127:0] block_t;
  typedef logic [127:0] key_t;

  localparam int num_rounds = 10;

  //////////////////////////////
  // Forward S-box
  //////////////////////////////
  localparam byte_t sbox_table [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  function automatic byte_t sbox(input byte_t b);
    return sbox_table[b];
  endfunction

  // Multiply by x modulo the AES polynomial 0x11b
  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Round constant for key schedule rounds 1 to 10
  function automatic byte_t rcon(input int round);
    case (round)
      1:       return 8'h01;
      2:       return 8'h02;
      3:       return 8'h04;
      4:       return 8'h08;
      5:       return 8'h10;
      6:       return 8'h20;
      7:       return 8'h40;
      8:       return 8'h80;
      9:       return 8'h1b;
      10:      return 8'h36;
      default: return 8'h00;
    endcase
  endfunction

endpackage

// ==== design/aes_stage_if.sv ====
//////////////////////////////
// AES pipeline stage link
// Valid, state, last added round key and user tag
//////////////////////////////
interface aes_stage_if #(
  parameter int TAG_W = 8
);
  import aes_pkg::*;

  logic             valid;
  block_t           state;
  // Key most recently XORed into state
  key_t             round_key;
  logic [TAG_W-1:0] tag;

  // Upstream stage drives the link
  modport src (output valid, state, round_key, tag);

  // Downstream stage reads it
  modport snk (input valid, state, round_key, tag);

endinterface

// ==== design/aes_key_step.sv ====
//////////////////////////////
// AES-128 key schedule step
// Derives the next round key from the current one
//////////////////////////////
module aes_key_step (
  input  aes_pkg::key_t  key_in,
  input  aes_pkg::byte_t round_rcon,
  output aes_pkg::key_t  key_out
);
  import aes_pkg::*;

  logic [31:0] w0, w1, w2, w3;
  logic [31:0] rot_word;
  logic [31:0] sub_word;
  logic [31:0] n0, n1, n2, n3;

  // Words in order, w0 is the most significant
  assign {w0, w1, w2, w3} = key_in;

  // RotWord of the last word
  assign rot_word = {w3[23:0], w3[31:24]};

  // SubWord, round constant lands on the leading byte
  assign sub_word = {sbox(rot_word[31:24]) ^ round_rcon,
                     sbox(rot_word[23:16]),
                     sbox(rot_word[15:8]),
                     sbox(rot_word[7:0])};

  // Chained XOR across the four words
  assign n0 = w0 ^ sub_word;
  assign n1 = w1 ^ n0;
  assign n2 = w2 ^ n1;
  assign n3 = w3 ^ n2;

  assign key_out = {n0, n1, n2, n3};

endmodule

// ==== design/aes_round.sv ====
//////////////////////////////
// AES cipher round
// One registered round with its own key derivation
//////////////////////////////
module aes_round #(
  parameter int ROUND = 1,
  parameter int TAG_W = 8
) (
  input  logic     clk,
  input  logic     rst_n,
  aes_stage_if.snk prev,
  aes_stage_if.src next
);
  import aes_pkg::*;

  localparam byte_t rcon_byte  = rcon(ROUND);
  // The final round leaves out MixColumns
  localparam bit    last_round = (ROUND == num_rounds);

  key_t             round_key;
  byte_t            shifted [16];
  logic [31:0]      col;
  logic [31:0]      col_mixed;
  block_t           round_out;

  logic             valid_q;
  block_t           state_q;
  key_t             key_q;
  logic [TAG_W-1:0] tag_q;

  // MixColumns on one column, top byte is row 0
  function automatic logic [31:0] mix_column(input logic [31:0] c_in);
    byte_t a0, a1, a2, a3;
    a0 = c_in[31:24];
    a1 = c_in[23:16];
    a2 = c_in[15:8];
    a3 = c_in[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // Key for this round, derived from the key carried with the block
  aes_key_step u_key_step (
    .key_in     (prev.round_key),
    .round_rcon (rcon_byte),
    .key_out    (round_key)
  );

  //////////////////////////////
  // SubBytes and ShiftRows
  //////////////////////////////
  // Row r of column c takes the byte from column c+r
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[4*c + r] = sbox(prev.state[127 - 8*(4*((c + r) % 4) + r) -: 8]);
      end
    end
  end

  //////////////////////////////
  // MixColumns and AddRoundKey
  //////////////////////////////
  always_comb begin
    col       = '0;
    col_mixed = '0;
    round_out = '0;
    for (int c = 0; c < 4; c++) begin
      col = {shifted[4*c], shifted[4*c + 1], shifted[4*c + 2], shifted[4*c + 3]};
      if (last_round) begin
        col_mixed = col;
      end else begin
        col_mixed = mix_column(col);
      end
      round_out[127 - 32*c -: 32] = col_mixed ^ round_key[127 - 32*c -: 32];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= prev.valid;
    end
  end

  // Payload only moves with a valid block
  always_ff @(posedge clk) begin
    if (prev.valid) begin
      state_q <= round_out;
      key_q   <= round_key;
      tag_q   <= prev.tag;
    end
  end

  assign next.valid     = valid_q;
  assign next.state     = state_q;
  assign next.round_key = key_q;
  assign next.tag       = tag_q;

endmodule

// ==== design/aes_input_stage.sv ====
//////////////////////////////
// AES input stage
// Initial AddRoundKey and pipeline entry register
//////////////////////////////
module aes_input_stage #(
  parameter int TAG_W = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  aes_pkg::block_t  in_text,
  input  aes_pkg::key_t    in_key,
  input  logic [TAG_W-1:0] in_tag,
  aes_stage_if.src         out
);
  import aes_pkg::*;

  logic             valid_q;
  block_t           state_q;
  key_t             key_q;
  logic [TAG_W-1:0] tag_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  // Round 0 key is the cipher key itself
  always_ff @(posedge clk) begin
    if (in_valid) begin
      state_q <= in_text ^ in_key;
      key_q   <= in_key;
      tag_q   <= in_tag;
    end
  end

  assign out.valid     = valid_q;
  assign out.state     = state_q;
  assign out.round_key = key_q;
  assign out.tag       = tag_q;

endmodule

// ==== design/aes_encryptor.sv ====
//////////////////////////////
// AES-128 encryptor
// Fully pipelined, key travels with each block
//////////////////////////////
module aes_encryptor #(
  parameter int TAG_W = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  aes_pkg::block_t  in_text,
  input  aes_pkg::key_t    in_key,
  input  logic [TAG_W-1:0] in_tag,
  output logic             out_valid,
  output aes_pkg::block_t  out_text,
  output logic [TAG_W-1:0] out_tag
);
  import aes_pkg::*;

  // Stage 0 is the input register, stage r the output of round r
  aes_stage_if #(.TAG_W(TAG_W)) stage [0:num_rounds] ();

  //////////////////////////////
  // Pipeline
  //////////////////////////////
  aes_input_stage #(
    .TAG_W (TAG_W)
  ) u_input_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_text  (in_text),
    .in_key   (in_key),
    .in_tag   (in_tag),
    .out      (stage[0])
  );

  for (genvar r = 1; r <= num_rounds; r++) begin : g_round
    aes_round #(
      .ROUND (r),
      .TAG_W (TAG_W)
    ) u_round (
      .clk   (clk),
      .rst_n (rst_n),
      .prev  (stage[r-1]),
      .next  (stage[r])
    );
  end

  // Last round register drives the outputs
  assign out_valid = stage[num_rounds].valid;
  assign out_text  = stage[num_rounds].state;
  assign out_tag   = stage[num_rounds].tag;

endmodule

// ==== tb/aes_tb.sv ====
//////////////////////////////
// AES encryptor testbench
// File driven vectors, random idle gaps, in-order result checks
//////////////////////////////
module aes_tb;
  import aes_pkg::*;

  localparam int    tag_w        = 8;
  localparam int    clk_period   = 4;
  localparam int    reset_cycles = 16;
  localparam int    latency      = 11;
  // Gap field value that asks for a random gap
  localparam int    rand_gap     = -1;
  localparam string stim_file    = "tb/aes_stim.txt";

  logic             clk = 1'b0;
  logic             rst_n;
  logic             in_valid;
  block_t           in_text;
  key_t             in_key;
  logic [tag_w-1:0] in_tag;
  logic             out_valid;
  block_t           out_text;
  logic [tag_w-1:0] out_tag;

  // Vectors in file order
  int               gap_q [$];
  logic [tag_w-1:0] tag_q [$];
  key_t             key_q [$];
  block_t           text_q [$];
  block_t           exp_q [$];
  int               num_blocks = 0;
  int               total_gap  = 0;

  // Cycle in which each strobe was seen, oldest first
  int               stamp_q [$];
  int               checked    = 0;
  logic [31:0]      lfsr_state = 32'h8f0a_a6dc;

  aes_encryptor #(
    .TAG_W (tag_w)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_text   (in_text),
    .in_key    (in_key),
    .in_tag    (in_tag),
    .out_valid (out_valid),
    .out_text  (out_text),
    .out_tag   (out_tag)
  );

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compare(input string what, input logic [127:0] got,
                         input logic [127:0] expected);
    if (got !== expected) begin
      stop_run($sformatf("Fail at %0t: %s is %0h, expected %0h",
                         $time, what, got, expected));
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic load_vectors();
    int               fd;
    int               n;
    int               g;
    logic [tag_w-1:0] t;
    key_t             k;
    block_t           p;
    block_t           c;
    string            line;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      stop_run({"Could not open the vector file ", stim_file});
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %h %h %h %h", g, t, k, p, c);
      // Blank lines fall through here
      if (n != 5) begin
        continue;
      end
      if (g == rand_gap) begin
        g = take_bits(2);
      end
      gap_q.push_back(g);
      tag_q.push_back(t);
      key_q.push_back(k);
      text_q.push_back(p);
      exp_q.push_back(c);
      total_gap  += g;
      num_blocks += 1;
    end
    $fclose(fd);
    if (num_blocks == 0) begin
      stop_run("The vector file holds no blocks");
    end
  endtask

  //////////////////////////////
  // Reset and driver
  //////////////////////////////
  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_text  = '0;
    in_key   = '0;
    in_tag   = '0;
    load_vectors();
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < num_blocks; i++) begin
      for (int g = 0; g < gap_q[i]; g++) begin
        in_valid <= 1'b0;
        @(posedge clk);
      end
      in_valid <= 1'b1;
      in_text  <= text_q[i];
      in_key   <= key_q[i];
      in_tag   <= tag_q[i];
      @(posedge clk);
    end
    in_valid <= 1'b0;
    wait (checked == num_blocks);
    // Few idle cycles so a stray strobe still gets caught
    repeat (4) @(negedge clk);
    $display("Result: PASSED");
    $finish;
  end

  //////////////////////////////
  // Monitor
  //////////////////////////////
  // Samples mid-cycle
  // A result is due exactly latency cycles after its strobe
  initial begin
    int   cycle;
    logic exp_valid;
    cycle = 0;
    forever begin
      @(negedge clk);
      cycle += 1;
      if (in_valid === 1'b1) begin
        stamp_q.push_back(cycle);
      end
      exp_valid = (stamp_q.size() > 0) && (cycle - stamp_q[0] == latency);
      compare("out_valid", 128'(out_valid), 128'(exp_valid));
      if (out_valid === 1'b1) begin
        compare("out_text", out_text, exp_q[checked]);
        compare("out_tag", 128'(out_tag), 128'(tag_q[checked]));
        void'(stamp_q.pop_front());
        checked += 1;
      end
    end
  end

  // Watchdog budget counts from reset release
  initial begin
    int limit;
    wait (rst_n === 1'b1);
    limit = (total_gap + num_blocks + latency + 20) * clk_period;
    #(limit);
    stop_run($sformatf("Timeout: not all results arrived within %0d time units", limit));
  end

endmodule

// ==== tb/aes_stim.txt ====
# gap tag key plaintext expected_ciphertext, gap in decimal and the rest in hex
# gap -1 takes 0 to 3 idle cycles from the testbench LFSR
0 01 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
3 02 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2 10 10a58869d74be5a374cf867cfb473859 00000000000000000000000000000000 6d251e6944b051e04eaa6fb4dbf78465
0 11 caea65cdbb75e9169ecd22ebe6e54675 00000000000000000000000000000000 6e29201190152df4ee058139def610bb
0 12 a2e2fa9baf7d20822ca9f0542f764a41 00000000000000000000000000000000 c3b44b95d9d2f25670eee9a0de099fa3
0 13 b6364ac4e1de1e285eaf144a2415f7a0 00000000000000000000000000000000 5d9b05578fc944b3cf1ccf0e746cd581
0 14 64cf9c7abc50b888af65f49d521944b2 00000000000000000000000000000000 f7efc89d5dba578104016ce5ad659c05
0 15 47d6742eefcc0465dc96355e851b64d9 00000000000000000000000000000000 0306194f666d183624aa230a8b264ae7
0 16 3eb39790678c56bee34bbcdeccf6cdb5 00000000000000000000000000000000 858075d536d79ccee571f7d7204b1f67
0 17 64110a924f0743d500ccadae72c13427 00000000000000000000000000000000 35870c6a57e9e92314bcb8087cde72ce
0 18 18d8126516f8a12ab1a36d9f04d68e51 00000000000000000000000000000000 6c68e9be5ec41e22c825b7c7affb4363
0 19 f530357968578480b398a3c251cd1093 00000000000000000000000000000000 f5df39990fc688f1b07224cc03e86cea
0 1a da84367f325d42d601b4326964802e8e 00000000000000000000000000000000 bba071bcb470f8f6586e5d3add18bc66
0 1b e37b1c6aa2846f6fdb413f238b089f23 00000000000000000000000000000000 43c9f7e62f5d288bb27aa40ef8fe1ea8
0 1c 6c002b682483e0cabcc731c253be5674 00000000000000000000000000000000 3580d19cff44f1014a7c966a69059de5
0 1d 143ae8ed6555aba96110ab58893a8ae1 00000000000000000000000000000000 806da864dd29d48deafbe764f8202aef
0 1e b69418a85332240dc82492353956ae0c 00000000000000000000000000000000 a303d940ded8f0baff6f75414cac5243
0 1f 71b5c08a1993e1362e4d0ce9b22b78d5 00000000000000000000000000000000 c2dabd117f8a3ecabfbb11d12194d9d0
0 20 e234cdca2606b81f29408d5f6da21206 00000000000000000000000000000000 fff60a4740086b3b9c56195b98d91a7b
0 21 13237c49074a3da078dc1d828bb78c6f 00000000000000000000000000000000 8146a08e2357f0caa30ca8c94d1a0544
0 22 3071a2a48fe6cbd04f1a129098e308f8 00000000000000000000000000000000 4b98e06d356deb07ebb824e5713f7be3
0 23 90f42ec0f68385f2ffc5dfc03a654dce 00000000000000000000000000000000 7a20a53d460fc9ce0423a7a0764c6cf2
0 24 febd9a24d8b65c1c787d50a4ed3619a9 00000000000000000000000000000000 f4a70d8af877f9b02b4c40df57d45b17
-1 30 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
-1 31 2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
-1 32 2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
-1 33 2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
-1 40 00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
-1 41 00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589
-1 42 00000000000000000000000000000000 96ab5c2ff612d9dfaae8c31f30c42168 ff4f8391a6a40ca5b25d23bedd44a597
-1 43 00000000000000000000000000000000 6a118a874519e64e9963798a503f1d35 dc43be40be0e53712f7e2bf5ca707209
-1 44 00000000000000000000000000000000 cb9fceec81286ca3e989bd979b0cb284 92beedab1895a94faa69b632e5cc47ce
-1 45 00000000000000000000000000000000 b26aeb1874e47ca8358ff22378f09144 459264f4798f6a78bacb89c15ed3d601
-1 46 00000000000000000000000000000000 58c8e00b2631686d54eab84b91f0aca1 08a4e2efec8a8e3312ca7460b9040bbf
0 50 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
0 51 00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34
0 52 80000000000000000000000000000000 00000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8

// ==== all.f ====
design/aes_pkg.sv
design/aes_stage_if.sv
design/aes_key_step.sv
design/aes_round.sv
design/aes_input_stage.sv
design/aes_encryptor.sv
tb/aes_tb.sv

// ==== Makefile ====
# Verilator build and run for the AES-128 encryptor testbench

VERILATOR ?= verilator
TOP       ?= aes_tb
RTL_TOP   ?= aes_encryptor
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall

SOURCES     := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter design/%,$(SOURCES))
SIM_BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

build: $(SIM_BIN)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
